//--- Bender.yml
package:
  name: usp

sources:
  - logic/usp_pkg.sv
  - logic/usp_cmd_regs.sv
  - logic/usp_tx_arbiter.sv
  - logic/usp_discover_reply.sv
  - logic/usp_ep6_packer.sv
  - logic/usp_top.sv
  - target: simulation
    files:
      - bench/usp_tb.sv

//--- bench/usp_tb.sv
// Testbench for usp_top with a stimulus table, FIFO model, byte-level reference model and watchdog
`timescale 1ns/1ps

module usp_tb import usp_pkg::*; ();

  localparam logic [7:0] id_nr    = 8'h02;
  localparam logic [7:0] id_major = 8'h14;
  localparam logic [7:0] id_minor = 8'h03;
  localparam logic [7:0] id_board = 8'h06;

  localparam int n_tests         = 8;
  localparam int watchdog_cycles = n_tests * 1100;

  typedef struct packed {
    logic [1:0]  kind;      // 0 discovery, 1 data packet, 2 both
    logic        run;
    logic        run_drop;  // Pulse run low first
    logic        port;
    logic        cmd;
    logic [31:0] cmd_rx;
    logic [31:0] cmd_tx;
    logic [3:0]  nrx;
  } test_t;

  logic        clk;
  logic        discover_rst;
  logic        have_ip;
  logic        run;
  logic [47:0] mac;
  logic        discover_rqst;
  logic        discover_port;
  logic        udp_tx_enable;
  logic [1:0]  udp_tx_request;
  logic [10:0] udp_tx_length;
  logic [7:0]  udp_tx_data;
  logic [23:0] us_tdata;
  logic        us_tlast;
  logic        us_tvalid;
  logic [10:0] us_tlength;
  logic        us_tready;
  logic [5:0]  cmd_addr;
  logic [31:0] cmd_data;
  logic        cmd_rqst;
  logic [39:0] resp;
  logic        resp_rqst;

  test_t       tests [0:n_tests-1];
  logic [7:0]  exp_bytes [0:1031];
  logic [23:0] sample_mem [0:4095];
  int          pop_cnt = 0;
  int          nrx = 1;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  // Reference copies of the setting registers
  logic [1:0]  sr_m = 2'd0;
  logic [3:0]  rx_m = 4'd0;
  logic [6:0]  lat_m = 7'd10;
  logic [4:0]  hang_m = 5'd4;

  usp_top #(
    .nr            (id_nr),
    .version_major (id_major),
    .version_minor (id_minor),
    .board         (id_board)
  ) usp_top_inst (
    .clk            (clk),
    .discover_rst   (discover_rst),
    .have_ip        (have_ip),
    .run            (run),
    .mac            (mac),
    .discover_rqst  (discover_rqst),
    .discover_port  (discover_port),
    .udp_tx_enable  (udp_tx_enable),
    .udp_tx_request (udp_tx_request),
    .udp_tx_length  (udp_tx_length),
    .udp_tx_data    (udp_tx_data),
    .us_tdata       (us_tdata),
    .us_tlast       (us_tlast),
    .us_tvalid      (us_tvalid),
    .us_tlength     (us_tlength),
    .us_tready      (us_tready),
    .cmd_addr       (cmd_addr),
    .cmd_data       (cmd_data),
    .cmd_rqst       (cmd_rqst),
    .resp           (resp),
    .resp_rqst      (resp_rqst)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Sample FIFO model with nrx words per round that advances on us_tready only
  initial begin
    int rpos;
    rpos = 0;
    us_tdata = 24'd0;
    us_tlast = 1'b0;
    forever begin
      @(posedge clk);
      if (us_tready) begin
        pop_cnt = pop_cnt + 1;
        rpos = (rpos == nrx - 1) ? 0 : rpos + 1;
      end
      us_tdata <= sample_mem[pop_cnt % 4096];
      us_tlast <= (rpos == nrx - 1);
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the simulation did not finish within %0d clock cycles", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

  function automatic test_t make_entry(input logic [1:0] kind, input logic run_en,
                                       input logic run_drop, input logic port, input logic cmd,
                                       input logic [31:0] cmd_rx, input logic [31:0] cmd_tx,
                                       input logic [3:0] n_rx);
    test_t e;
    e.kind     = kind;
    e.run      = run_en;
    e.run_drop = run_drop;
    e.port     = port;
    e.cmd      = cmd;
    e.cmd_rx   = cmd_rx;
    e.cmd_tx   = cmd_tx;
    e.nrx      = n_rx;
    return e;
  endfunction

  function automatic string kind_name(input logic [1:0] kind);
    if (kind == 2'd0)
      return "discovery";
    else if (kind == 2'd1)
      return "data packet";
    return "discovery and data packet";
  endfunction

  // Called just after a rising edge
  task automatic write_cmd(input logic [5:0] addr, input logic [31:0] data);
    cmd_addr <= addr;
    cmd_data <= data;
    cmd_rqst <= 1'b1;
    @(posedge clk);
    cmd_rqst <= 1'b0;
    if (addr == 6'h00) begin
      sr_m = data[25:24];
      rx_m = data[6:3];
    end else if (addr == 6'h17) begin
      lat_m  = data[6:0];
      hang_m = data[12:8];
    end
    @(posedge clk);
  endtask

  task automatic build_discover(input logic run_now, input logic [47:0] mac_val);
    int i;
    for (i = 0; i < 1032; i++)
      exp_bytes[i] = 8'h00;
    exp_bytes[0] = 8'hef;
    exp_bytes[1] = 8'hfe;
    exp_bytes[2] = run_now ? 8'h03 : 8'h02;
    for (i = 0; i < 6; i++)
      exp_bytes[3 + i] = mac_val[47 - 8 * i -: 8];
    exp_bytes[9]  = id_major;
    exp_bytes[10] = id_board;
    exp_bytes[11] = id_nr;
    exp_bytes[12] = id_minor;
    exp_bytes[13] = {1'b0, lat_m};
    exp_bytes[14] = {3'b000, hang_m};
    exp_bytes[15] = {sr_m, 2'b00, rx_m};
  endtask

  task automatic build_ep6(input logic [19:0] seq, input int n_rx, input logic [39:0] r,
                           input int base, output int words);
    int i;
    int h;
    int p;
    int o;
    int w;
    int k;
    int len;
    for (i = 0; i < 1032; i++)
      exp_bytes[i] = 8'h00;
    exp_bytes[0] = 8'hef;
    exp_bytes[1] = 8'hfe;
    exp_bytes[2] = 8'h01;
    exp_bytes[3] = 8'h06;
    exp_bytes[5] = {4'h0, seq[19:16]};
    exp_bytes[6] = seq[15:8];
    exp_bytes[7] = seq[7:0];
    k = base;
    len = 3 * n_rx + 2;  // Round length with the mic bytes
    for (h = 0; h < 2; h++) begin
      p = 8 + 512 * h;
      for (i = 0; i < 3; i++)
        exp_bytes[p + i] = 8'h7f;
      for (i = 0; i < 5; i++)
        exp_bytes[p + 3 + i] = r[39 - 8 * i -: 8];
      o = 8;
      do begin
        for (w = 0; w < n_rx; w++) begin
          exp_bytes[p + o]     = sample_mem[k % 4096][23:16];
          exp_bytes[p + o + 1] = sample_mem[k % 4096][15:8];
          exp_bytes[p + o + 2] = sample_mem[k % 4096][7:0];
          o = o + 3;
          k = k + 1;
        end
        o = o + 2;  // Mic bytes stay zero
      end while (512 - o > len);
    end
    words = k - base;
  endtask

  // Waits for the request, enables and checks every byte of the payload
  task automatic transfer(input int n, input logic [1:0] req_exp, output int pops,
                          output int toggles);
    int   i;
    logic last_rr;
    pops = 0;
    toggles = 0;
    @(posedge clk);
    while (udp_tx_request == 2'b00)
      @(posedge clk);
    if (udp_tx_request !== req_exp) begin
      err_cnt++;
      $display("FAILED at %0d ns: request %b, expected %b", $time, udp_tx_request, req_exp);
    end
    if (udp_tx_length !== 11'(n)) begin
      err_cnt++;
      $display("FAILED at %0d ns: length %0d, expected %0d", $time, udp_tx_length, n);
    end
    if (udp_tx_data !== 8'hef) begin
      err_cnt++;
      $display("FAILED at %0d ns: data %02h while requesting, expected ef", $time, udp_tx_data);
    end
    udp_tx_enable <= 1'b1;
    if (req_exp == 2'b10) begin
      us_tvalid  <= 1'b0;
      us_tlength <= 11'd0;
    end
    last_rr = resp_rqst;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      udp_tx_enable <= 1'b0;
      if (udp_tx_data !== exp_bytes[i]) begin
        err_cnt++;
        $display("FAILED at %0d ns: byte %0d is %02h, expected %02h", $time, i, udp_tx_data,
                 exp_bytes[i]);
      end
      if (us_tready)
        pops++;
      if (resp_rqst != last_rr)
        toggles++;
      last_rr = resp_rqst;
    end
    @(posedge clk);
    if (udp_tx_request !== 2'b00) begin
      err_cnt++;
      $display("FAILED at %0d ns: request %b after the last byte", $time, udp_tx_request);
    end
  endtask

  initial begin
    test_t       e;
    logic [31:0] rnd;
    logic [47:0] mac_val;
    logic [39:0] resp_val;
    int          seq_exp;
    int          t;
    int          i;
    int          err_before;
    int          base;
    int          words;
    int          pops;
    int          toggles;

    rnd = $urandom(47);
    discover_rst  = 1'b1;
    have_ip       = 1'b0;
    run           = 1'b0;
    mac           = 48'd0;
    discover_rqst = 1'b0;
    discover_port = 1'b0;
    udp_tx_enable = 1'b0;
    us_tvalid     = 1'b0;
    us_tlength    = 11'd0;
    cmd_addr      = 6'd0;
    cmd_data      = 32'd0;
    cmd_rqst      = 1'b0;
    resp          = 40'd0;
    seq_exp = 0;
    for (i = 0; i < 4096; i++) begin
      rnd = $urandom;
      sample_mem[i] = rnd[23:0];
    end

    tests[0] = make_entry(2'd0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 4'd1);
    tests[1] = make_entry(2'd0, 1'b0, 1'b0, 1'b1, 1'b0, 32'h0, 32'h0, 4'd1);
    tests[2] = make_entry(2'd0, 1'b1, 1'b0, 1'b0, 1'b1, 32'h0200_0030, 32'h0000_1325, 4'd1);
    tests[3] = make_entry(2'd1, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 4'd1);
    tests[4] = make_entry(2'd1, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 4'd3);
    tests[5] = make_entry(2'd1, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 4'd7);
    tests[6] = make_entry(2'd1, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0, 32'h0, 4'd3);
    tests[7] = make_entry(2'd2, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0, 32'h0, 4'd2);

    repeat (4) @(posedge clk);
    discover_rst <= 1'b0;
    have_ip      <= 1'b1;
    @(posedge clk);

    err_before = err_cnt;
    if (udp_tx_request !== 2'b00 || us_tready !== 1'b0 || resp_rqst !== 1'b0) begin
      err_cnt++;
      $display("FAILED at %0d ns: outputs not idle after reset", $time);
    end
    if (err_cnt == err_before) pass_cnt++; else fail_cnt++;
    $display("Reset state: %0d errors", err_cnt - err_before);

    for (t = 0; t < n_tests; t++) begin
      e = tests[t];
      err_before = err_cnt;
      if (e.cmd) begin
        write_cmd(cmd_addr_rx, e.cmd_rx);
        write_cmd(cmd_addr_tx, e.cmd_tx);
      end
      if (e.run_drop) begin
        run <= 1'b0;
        seq_exp = 0;
        repeat (3) @(posedge clk);
      end
      run <= e.run;
      if (!e.run)
        seq_exp = 0;  // Stopped radio clears the sequence
      nrx = e.nrx;
      rnd = $urandom;
      mac_val[47:32] = rnd[15:0];
      mac_val[31:0] = $urandom;
      rnd = $urandom;
      resp_val[39:32] = rnd[7:0];
      resp_val[31:0] = $urandom;
      mac  <= mac_val;
      resp <= resp_val;
      @(posedge clk);

      if (e.kind != 2'd1) begin
        build_discover(e.run, mac_val);
        discover_port <= e.port;
        discover_rqst <= 1'b1;
        @(posedge clk);
        discover_rqst <= 1'b0;
        if (e.kind == 2'd2) begin
          // FIFO turns ready while the discovery request is pending
          us_tlength <= 11'd400;
          us_tvalid  <= 1'b1;
        end
        transfer(60, {1'b1, e.port}, pops, toggles);
      end

      if (e.kind != 2'd0) begin
        base = pop_cnt;
        build_ep6(20'(seq_exp), e.nrx, resp_val, base, words);
        us_tlength <= 11'd400;
        us_tvalid  <= 1'b1;
        transfer(1032, 2'b10, pops, toggles);
        if (pops != words) begin
          err_cnt++;
          $display("FAILED at %0d ns: %0d us_tready pulses, expected %0d", $time, pops, words);
        end
        if (toggles != 2) begin
          err_cnt++;
          $display("FAILED at %0d ns: resp_rqst toggled %0d times, expected 2", $time,
                   toggles);
        end
        seq_exp++;
      end

      if (err_cnt == err_before) pass_cnt++; else fail_cnt++;
      $display("Test %0d (%s, %0d receivers): %0d errors", t, kind_name(e.kind), e.nrx,
               err_cnt - err_before);
    end

    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- compile.f
logic/usp_pkg.sv
logic/usp_cmd_regs.sv
logic/usp_tx_arbiter.sv
logic/usp_discover_reply.sv
logic/usp_ep6_packer.sv
logic/usp_top.sv
bench/usp_tb.sv

//--- logic/usp_cmd_regs.sv
// Command address decoder and radio setting registers
`timescale 1ns/1ps

module usp_cmd_regs import usp_pkg::*; (
  input  logic        clk,
  input  logic        discover_rst,
  input  logic [5:0]  cmd_addr,
  input  logic [31:0] cmd_data,
  input  logic        cmd_rqst,
  output logic [1:0]  sample_rate,
  output logic [3:0]  receivers,
  output logic [6:0]  tx_buffer_latency,
  output logic [4:0]  ptt_hang_time
);

  logic hit_rx;
  logic hit_tx;

  assign hit_rx = cmd_rqst && (cmd_addr == cmd_addr_rx);
  assign hit_tx = cmd_rqst && (cmd_addr == cmd_addr_tx);

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      sample_rate       <= 2'd0;
      receivers         <= 4'd0;
      tx_buffer_latency <= tx_latency_default;
      ptt_hang_time     <= ptt_hang_default;
    end else begin
      if (hit_rx) begin
        sample_rate <= cmd_data[25:24];
        receivers   <= cmd_data[6:3];   // Receiver count minus one
      end
      if (hit_tx) begin
        tx_buffer_latency <= cmd_data[6:0];
        ptt_hang_time     <= cmd_data[12:8];
      end
    end
  end

endmodule

//--- logic/usp_discover_reply.sv
// Byte generator for the 60-byte discovery reply
`timescale 1ns/1ps

module usp_discover_reply import usp_pkg::*; #(
  parameter logic [7:0] nr            = 8'h00,
  parameter logic [7:0] version_major = 8'h00,
  parameter logic [7:0] version_minor = 8'h00,
  parameter logic [7:0] board         = 8'h00
) (
  input  logic        clk,
  input  logic        discover_rst,
  input  logic        discover_start,
  input  logic        run,
  input  logic [47:0] mac,
  input  logic [1:0]  sample_rate,
  input  logic [3:0]  receivers,
  input  logic [6:0]  tx_buffer_latency,
  input  logic [4:0]  ptt_hang_time,
  output logic [7:0]  discover_byte,
  output logic        discover_done
);

  logic [5:0] idx;        // Index of the byte on discover_byte
  logic [5:0] idx_next;
  logic       active;
  logic       last;
  logic [7:0] byte_next;

  assign last          = ({5'd0, idx} == discover_len - 11'd1);
  assign idx_next      = discover_start ? 6'd1 : idx + 6'd1;
  assign discover_done = active && last;

  always_comb begin
    case (idx_next)
      6'd1:    byte_next = sync_lo;
      6'd2:    byte_next = run ? 8'h03 : 8'h02;  // Running or idle
      6'd3:    byte_next = mac[47:40];
      6'd4:    byte_next = mac[39:32];
      6'd5:    byte_next = mac[31:24];
      6'd6:    byte_next = mac[23:16];
      6'd7:    byte_next = mac[15:8];
      6'd8:    byte_next = mac[7:0];
      6'd9:    byte_next = version_major;
      6'd10:   byte_next = board;
      6'd11:   byte_next = nr;
      6'd12:   byte_next = version_minor;
      6'd13:   byte_next = {1'b0, tx_buffer_latency};
      6'd14:   byte_next = {3'b000, ptt_hang_time};
      6'd15:   byte_next = {sample_rate, 2'b00, receivers};
      default: byte_next = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      active <= 1'b0;
      idx    <= 6'd0;
    end else if (discover_start) begin
      active <= 1'b1;
      idx    <= idx_next;
    end else if (active) begin
      // Stop after byte 59
      active <= !last;
      idx    <= last ? 6'd0 : idx_next;
    end
  end

  always_ff @(posedge clk) begin
    if (discover_start || (active && !last))
      discover_byte <= byte_next;
    else
      discover_byte <= 8'h00;
  end

endmodule

//--- logic/usp_ep6_packer.sv
// Receive-data packet framer with header, sequence number, response slots, rounds and padding
`timescale 1ns/1ps

module usp_ep6_packer import usp_pkg::*; (
  input  logic        clk,
  input  logic        discover_rst,
  input  logic        run,
  input  logic        ep6_start,
  input  logic [23:0] us_tdata,
  input  logic        us_tlast,
  input  logic [39:0] resp,
  output logic [7:0]  ep6_byte,
  output logic        ep6_done,
  output logic        us_tready,
  output logic        resp_rqst
);

  typedef enum logic [3:0] {
    st_idle, st_hdr, st_sync, st_rx2, st_rx1, st_rx0, st_mic1, st_mic0, st_pad
  } state_t;

  state_t      state;
  state_t      state_next;
  logic [10:0] idx;        // Index of the byte on ep6_byte
  logic [8:0]  off;        // Offset within the current half
  logic [8:0]  left;       // Bytes still to come in this half
  logic [6:0]  round_cnt;
  logic [19:0] seq_no;
  logic        half_end;
  logic        pkt_end;
  logic        seq_inc;

  assign off      = idx[8:0] - 9'd8;
  assign left     = ~off;
  assign half_end = ({1'b0, off} == half_len - 10'd1);
  assign pkt_end  = (idx == ep6_len - 11'd1);
  assign seq_inc  = (state == st_hdr) && (idx == 11'd7);

  assign ep6_done  = (state != st_idle) && pkt_end;
  assign us_tready = (state == st_rx0);  // Pop on the low byte

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (ep6_start) state_next = st_hdr;
      st_hdr:  if (idx == 11'd7) state_next = st_sync;
      st_sync: if (off == 9'd7) state_next = st_rx2;
      st_rx2:  state_next = st_rx1;
      st_rx1:  state_next = st_rx0;
      st_rx0:  state_next = us_tlast ? st_mic1 : st_rx2;
      st_mic1: state_next = st_mic0;
      // Another round only if it fits
      st_mic0: state_next = (left > {2'b00, round_cnt} + 9'd1) ? st_rx2 : st_pad;
      default: state_next = state;
    endcase
    if (state != st_idle && state != st_hdr && half_end)
      state_next = pkt_end ? st_idle : st_sync;
  end

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      state     <= st_idle;
      idx       <= 11'd0;
      round_cnt <= 7'd0;
      resp_rqst <= 1'b0;
    end else begin
      state <= state_next;
      idx   <= (state_next == st_idle) ? 11'd0 : idx + 11'd1;

      if (state == st_sync || state == st_mic0)
        round_cnt <= 7'd0;
      else if (state inside {st_rx2, st_rx1, st_rx0, st_mic1})
        round_cnt <= round_cnt + 7'd1;

      if (state == st_sync && off == 9'd7)
        resp_rqst <= ~resp_rqst;  // Response consumed
    end
  end

  // Sequence number held at zero while stopped
  always_ff @(posedge clk) begin
    if (discover_rst || !run)
      seq_no <= 20'd0;
    else if (seq_inc)
      seq_no <= seq_no + 20'd1;
  end

  always_comb begin
    ep6_byte = 8'h00;
    case (state)
      st_hdr: begin
        case (idx[2:0])
          3'd1:    ep6_byte = sync_lo;
          3'd2:    ep6_byte = ep6_type[1];
          3'd3:    ep6_byte = ep6_type[0];
          3'd5:    ep6_byte = {4'h0, seq_no[19:16]};
          3'd6:    ep6_byte = seq_no[15:8];
          3'd7:    ep6_byte = seq_no[7:0];
          default: ep6_byte = 8'h00;
        endcase
      end
      st_sync: begin
        case (off[2:0])
          3'd3:    ep6_byte = resp[39:32];
          3'd4:    ep6_byte = resp[31:24];
          3'd5:    ep6_byte = resp[23:16];
          3'd6:    ep6_byte = resp[15:8];
          3'd7:    ep6_byte = resp[7:0];
          default: ep6_byte = half_sync;
        endcase
      end
      st_rx2:  ep6_byte = us_tdata[23:16];
      st_rx1:  ep6_byte = us_tdata[15:8];
      st_rx0:  ep6_byte = us_tdata[7:0];
      default: ep6_byte = 8'h00;  // Mic bytes and padding
    endcase
  end

endmodule

//--- logic/usp_pkg.sv
// Upstream protocol constants, byte counts and the reply source encoding
package usp_pkg;

  // Frame sync bytes
  localparam logic [7:0] sync_hi = 8'hef;
  localparam logic [7:0] sync_lo = 8'hfe;

  // Receive-data type bytes with [1] sent first
  localparam logic [1:0][7:0] ep6_type = {8'h01, 8'h06};

  localparam logic [7:0] half_sync = 8'h7f;  // Three of these open each half

  // Payload lengths in bytes
  localparam logic [10:0] discover_len = 11'd60;
  localparam logic [10:0] ep6_len      = 11'd1032;
  localparam logic [9:0]  half_len     = 10'd512;

  // FIFO level that must be passed before a packet may start
  localparam logic [10:0] ep6_fill_min = 11'd333;

  // Command addresses
  localparam logic [5:0] cmd_addr_rx = 6'h00;
  localparam logic [5:0] cmd_addr_tx = 6'h17;

  localparam logic [6:0] tx_latency_default = 7'd10;  // ms
  localparam logic [4:0] ptt_hang_default   = 5'd4;   // ms

  // Which generator owns the transmitter
  typedef enum logic [1:0] {
    tx_idle     = 2'd0,
    tx_discover = 2'd1,
    tx_ep6      = 2'd2
  } tx_src_t;

endpackage

//--- logic/usp_top.sv
// Upstream packer top level with command registers, arbiter and both generators
`timescale 1ns/1ps

module usp_top #(
  parameter logic [7:0] nr            = 8'h00,
  parameter logic [7:0] version_major = 8'h00,
  parameter logic [7:0] version_minor = 8'h00,
  parameter logic [7:0] board         = 8'h05
) (
  input  logic        clk,
  input  logic        discover_rst,
  input  logic        have_ip,
  input  logic        run,
  input  logic [47:0] mac,
  input  logic        discover_rqst,
  input  logic        discover_port,
  input  logic        udp_tx_enable,
  output logic [1:0]  udp_tx_request,
  output logic [10:0] udp_tx_length,
  output logic [7:0]  udp_tx_data,
  input  logic [23:0] us_tdata,
  input  logic        us_tlast,
  input  logic        us_tvalid,
  input  logic [10:0] us_tlength,
  output logic        us_tready,
  input  logic [5:0]  cmd_addr,
  input  logic [31:0] cmd_data,
  input  logic        cmd_rqst,
  input  logic [39:0] resp,
  output logic        resp_rqst
);

  logic [1:0] sample_rate;
  logic [3:0] receivers;
  logic [6:0] tx_buffer_latency;
  logic [4:0] ptt_hang_time;
  logic       discover_start;
  logic       discover_done;
  logic [7:0] discover_byte;
  logic       ep6_start;
  logic       ep6_done;
  logic [7:0] ep6_byte;

  usp_cmd_regs usp_cmd_regs_inst (
    .clk               (clk),
    .discover_rst      (discover_rst),
    .cmd_addr          (cmd_addr),
    .cmd_data          (cmd_data),
    .cmd_rqst          (cmd_rqst),
    .sample_rate       (sample_rate),
    .receivers         (receivers),
    .tx_buffer_latency (tx_buffer_latency),
    .ptt_hang_time     (ptt_hang_time)
  );

  usp_tx_arbiter usp_tx_arbiter_inst (
    .clk            (clk),
    .discover_rst   (discover_rst),
    .have_ip        (have_ip),
    .run            (run),
    .discover_rqst  (discover_rqst),
    .discover_port  (discover_port),
    .us_tvalid      (us_tvalid),
    .us_tlength     (us_tlength),
    .udp_tx_enable  (udp_tx_enable),
    .discover_done  (discover_done),
    .ep6_done       (ep6_done),
    .discover_byte  (discover_byte),
    .ep6_byte       (ep6_byte),
    .udp_tx_request (udp_tx_request),
    .udp_tx_length  (udp_tx_length),
    .udp_tx_data    (udp_tx_data),
    .discover_start (discover_start),
    .ep6_start      (ep6_start)
  );

  usp_discover_reply #(
    .nr            (nr),
    .version_major (version_major),
    .version_minor (version_minor),
    .board         (board)
  ) usp_discover_reply_inst (
    .clk               (clk),
    .discover_rst      (discover_rst),
    .discover_start    (discover_start),
    .run               (run),
    .mac               (mac),
    .sample_rate       (sample_rate),
    .receivers         (receivers),
    .tx_buffer_latency (tx_buffer_latency),
    .ptt_hang_time     (ptt_hang_time),
    .discover_byte     (discover_byte),
    .discover_done     (discover_done)
  );

  usp_ep6_packer usp_ep6_packer_inst (
    .clk          (clk),
    .discover_rst (discover_rst),
    .run          (run),
    .ep6_start    (ep6_start),
    .us_tdata     (us_tdata),
    .us_tlast     (us_tlast),
    .resp         (resp),
    .ep6_byte     (ep6_byte),
    .ep6_done     (ep6_done),
    .us_tready    (us_tready),
    .resp_rqst    (resp_rqst)
  );

endmodule

//--- logic/usp_tx_arbiter.sv
// Discovery request latch, payload choice, transmitter request and output byte mux
`timescale 1ns/1ps

module usp_tx_arbiter import usp_pkg::*; (
  input  logic        clk,
  input  logic        discover_rst,
  input  logic        have_ip,
  input  logic        run,
  input  logic        discover_rqst,
  input  logic        discover_port,
  input  logic        us_tvalid,
  input  logic [10:0] us_tlength,
  input  logic        udp_tx_enable,
  input  logic        discover_done,
  input  logic        ep6_done,
  input  logic [7:0]  discover_byte,
  input  logic [7:0]  ep6_byte,
  output logic [1:0]  udp_tx_request,
  output logic [10:0] udp_tx_length,
  output logic [7:0]  udp_tx_data,
  output logic        discover_start,
  output logic        ep6_start
);

  tx_src_t src;
  logic    requesting;
  logic    disc_pending;
  logic    disc_port_q;
  logic    ep6_ready;

  assign ep6_ready = (us_tlength > ep6_fill_min) && us_tvalid && have_ip && run;

  assign discover_start = requesting && (src == tx_discover) && udp_tx_enable;
  assign ep6_start      = requesting && (src == tx_ep6) && udp_tx_enable;

  always_comb begin
    udp_tx_request = 2'b00;
    if (requesting)
      udp_tx_request = (src == tx_discover) ? {1'b1, disc_port_q} : 2'b10;
  end

  // EF goes out while waiting, so byte 0 is ready in the enable cycle
  always_comb begin
    case (src)
      tx_discover: udp_tx_data = discover_byte;
      tx_ep6:      udp_tx_data = ep6_byte;
      default:     udp_tx_data = 8'h00;
    endcase
    if (requesting)
      udp_tx_data = sync_hi;
  end

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      src          <= tx_idle;
      requesting   <= 1'b0;
      disc_pending <= 1'b0;
      disc_port_q  <= 1'b0;
    end else begin
      if (discover_start) begin
        disc_pending <= 1'b0;
      end else if (discover_rqst && !disc_pending) begin
        disc_pending <= 1'b1;
        disc_port_q  <= discover_port;
      end

      case (src)
        tx_idle: begin
          if (disc_pending) begin  // Discovery wins
            src        <= tx_discover;
            requesting <= 1'b1;
          end else if (ep6_ready) begin
            src        <= tx_ep6;
            requesting <= 1'b1;
          end
        end
        default: begin
          if (udp_tx_enable)
            requesting <= 1'b0;
          if ((src == tx_discover && discover_done) || (src == tx_ep6 && ep6_done))
            src <= tx_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (src == tx_idle)
      udp_tx_length <= disc_pending ? discover_len : ep6_len;
  end

endmodule
